// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // ------------------------------------------------------------------------
    // datapath sizing
    // ------------------------------------------------------------------------
    parameter int xlen           = 64;  // one integer register.
    parameter int reg_addr_width = 5;   // x0..x31 index.
    parameter int reg_count      = 32;  // integer register file depth.

    // alu operations carried from decode to execute.
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl
    } alu_op_t;

    // the only major opcode handled, r-type op.
    parameter logic [6:0] opcode_op = 7'b0110011;

    // ------------------------------------------------------------------------
    // apb address map
    // ------------------------------------------------------------------------
    parameter int apb_addr_width = 12;

    parameter logic [apb_addr_width-1:0] addr_reg_base = 12'h000;  // xn at base + n*8.
    parameter logic [apb_addr_width-1:0] addr_retired  = 12'h100;  // retired counter.
    parameter logic [apb_addr_width-1:0] addr_illegal  = 12'h108;  // dropped words.

endpackage

`default_nettype wire

// ==== design/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [31:0]                         instr,
    output logic                                rd_valid,
    output exec_pkg::alu_op_t                   rd_op,
    output logic [exec_pkg::reg_addr_width-1:0] rd_rs1,
    output logic [exec_pkg::reg_addr_width-1:0] rd_rs2,
    output logic [exec_pkg::reg_addr_width-1:0] rd_rd,
    output logic [31:0]                         illegal_count
);
    import exec_pkg::*;

    logic    legal;   // word matches one of the seven encodings.
    alu_op_t dec_op;  // decoded operation.

    // r-type field split.
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        legal  = 1'b0;
        dec_op = alu_add;
        if (opcode == opcode_op) begin
            case (funct3)
                3'b000: begin
                    if (funct7 == 7'b0000000) begin
                        legal = 1'b1;  // add.
                    end else if (funct7 == 7'b0100000) begin
                        legal  = 1'b1;  // sub.
                        dec_op = alu_sub;
                    end
                end
                3'b001: begin
                    legal  = (funct7 == 7'b0);
                    dec_op = alu_sll;
                end
                3'b100: begin
                    legal  = (funct7 == 7'b0);
                    dec_op = alu_xor;
                end
                3'b101: begin
                    legal  = (funct7 == 7'b0);  // sra has funct7 0100000.
                    dec_op = alu_srl;
                end
                3'b110: begin
                    legal  = (funct7 == 7'b0);
                    dec_op = alu_or;
                end
                3'b111: begin
                    legal  = (funct7 == 7'b0);
                    dec_op = alu_and;
                end
                default: legal = 1'b0;  // slt and sltu dropped.
            endcase
        end
    end

    // only legal words enter the read stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid      <= 1'b0;
            illegal_count <= '0;
        end else begin
            rd_valid <= instr_valid && legal;
            if (instr_valid && !legal && (illegal_count != '1)) begin
                illegal_count <= illegal_count + 32'd1;  // saturates at all ones.
            end
        end
    end

    // read stage payload.
    always_ff @(posedge clk) begin
        if (instr_valid && legal) begin
            rd_op  <= dec_op;
            rd_rs1 <= instr[19:15];
            rd_rs2 <= instr[24:20];
            rd_rd  <= instr[11:7];
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int xlen      = exec_pkg::xlen,
    parameter int reg_count = exec_pkg::reg_count
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [exec_pkg::reg_addr_width-1:0] rs1,
    input  logic [exec_pkg::reg_addr_width-1:0] rs2,
    input  logic                                wb_en,
    input  logic [exec_pkg::reg_addr_width-1:0] wb_addr,
    input  logic [xlen-1:0]                     wb_data,
    input  logic                                apb_we,
    input  logic [exec_pkg::reg_addr_width-1:0] apb_addr,
    input  logic [xlen-1:0]                     apb_wdata,
    output logic [xlen-1:0]                     rs1_data,
    output logic [xlen-1:0]                     rs2_data,
    output logic [xlen-1:0]                     apb_rdata
);
    import exec_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    // write-back and apb never fire in the same cycle, apb waits for an empty pipe.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_en && (wb_addr != '0)) begin
                regs[wb_addr] <= wb_data;  // retiring instruction.
            end
            if (apb_we && (apb_addr != '0)) begin
                regs[apb_addr] <= apb_wdata;  // preload from the bus.
            end
        end
    end

    // combinational reads, x0 hardwired.
    assign rs1_data  = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data  = (rs2 == '0) ? '0 : regs[rs2];
    assign apb_rdata = (apb_addr == '0) ? '0 : regs[apb_addr];

endmodule

`default_nettype wire

// ==== design/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bypass #(
    parameter int xlen = exec_pkg::xlen
) (
    input  logic [exec_pkg::reg_addr_width-1:0] rs1,
    input  logic [exec_pkg::reg_addr_width-1:0] rs2,
    input  logic [xlen-1:0]                     rs1_file,
    input  logic [xlen-1:0]                     rs2_file,
    input  logic                                ex_valid,
    input  logic [exec_pkg::reg_addr_width-1:0] ex_rd,
    input  logic [xlen-1:0]                     ex_result,
    input  logic                                mem_valid,
    input  logic [exec_pkg::reg_addr_width-1:0] mem_rd,
    input  logic [xlen-1:0]                     mem_result,
    input  logic                                wb_valid,
    input  logic [exec_pkg::reg_addr_width-1:0] wb_rd,
    input  logic [xlen-1:0]                     wb_result,
    output logic [xlen-1:0]                     op_a,
    output logic [xlen-1:0]                     op_b
);

    // ------------------------------------------------------------------------
    // newest producer wins in the order execute, memory, write-back, file
    // ------------------------------------------------------------------------
    always_comb begin
        op_a = rs1_file;  // no in-flight producer.
        if (rs1 != '0) begin
            if (ex_valid && (ex_rd == rs1)) begin
                op_a = ex_result;  // one ahead at the alu output.
            end else if (mem_valid && (mem_rd == rs1)) begin
                op_a = mem_result;  // two ahead.
            end else if (wb_valid && (wb_rd == rs1)) begin
                op_a = wb_result;  // being written this edge.
            end
        end
    end

    // same selection for the second source.
    always_comb begin
        op_b = rs2_file;
        if (rs2 != '0) begin
            if (ex_valid && (ex_rd == rs2)) begin
                op_b = ex_result;
            end else if (mem_valid && (mem_rd == rs2)) begin
                op_b = mem_result;
            end else if (wb_valid && (wb_rd == rs2)) begin
                op_b = wb_result;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_pipe #(
    parameter int xlen = exec_pkg::xlen
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                rd_valid,
    input  exec_pkg::alu_op_t                   rd_op,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_rd,
    input  logic [xlen-1:0]                     op_a,
    input  logic [xlen-1:0]                     op_b,
    output logic                                ex_valid,
    output logic [exec_pkg::reg_addr_width-1:0] ex_rd,
    output logic [xlen-1:0]                     ex_result,
    output logic                                mem_valid,
    output logic [exec_pkg::reg_addr_width-1:0] mem_rd,
    output logic [xlen-1:0]                     mem_result,
    output logic                                wb_valid,
    output logic [exec_pkg::reg_addr_width-1:0] wb_rd,
    output logic [xlen-1:0]                     wb_result,
    output logic [31:0]                         retired_count,
    output logic                                busy
);
    import exec_pkg::*;

    localparam int shamt_width = $clog2(xlen);  // 6 bits for rv64.

    alu_op_t                  ex_op;
    logic [xlen-1:0]          ex_a;
    logic [xlen-1:0]          ex_b;
    logic [shamt_width-1:0]   shamt;

    // ------------------------------------------------------------------------
    // stage valids and retire count
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid      <= 1'b0;
            mem_valid     <= 1'b0;
            wb_valid      <= 1'b0;
            retired_count <= '0;
        end else begin
            ex_valid  <= rd_valid;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
            if (wb_valid) begin
                retired_count <= retired_count + 32'd1;  // same edge as the file write.
            end
        end
    end

    // stage payloads.
    always_ff @(posedge clk) begin
        ex_op      <= rd_op;
        ex_rd      <= rd_rd;
        ex_a       <= op_a;
        ex_b       <= op_b;
        mem_rd     <= ex_rd;
        mem_result <= ex_result;
        wb_rd      <= mem_rd;
        wb_result  <= mem_result;
    end

    // ------------------------------------------------------------------------
    // alu
    // ------------------------------------------------------------------------
    assign shamt = ex_b[shamt_width-1:0];

    always_comb begin
        case (ex_op)
            alu_add: ex_result = ex_a + ex_b;
            alu_sub: ex_result = ex_a - ex_b;
            alu_and: ex_result = ex_a & ex_b;
            alu_or:  ex_result = ex_a | ex_b;
            alu_xor: ex_result = ex_a ^ ex_b;
            alu_sll: ex_result = ex_a << shamt;
            alu_srl: ex_result = ex_a >> shamt;  // logical, zero fill.
            default: ex_result = '0;
        endcase
    end

    assign busy = rd_valid | ex_valid | mem_valid | wb_valid;  // anything in flight.

endmodule

`default_nettype wire

// ==== design/apb_state_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_state_port #(
    parameter int xlen = exec_pkg::xlen
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [exec_pkg::apb_addr_width-1:0] paddr,
    input  logic [xlen-1:0]                     pwdata,
    input  logic                                busy,
    input  logic [xlen-1:0]                     reg_rdata,
    input  logic [31:0]                         retired_count,
    input  logic [31:0]                         illegal_count,
    output logic [xlen-1:0]                     prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                reg_we,
    output logic [exec_pkg::reg_addr_width-1:0] reg_addr,
    output logic [xlen-1:0]                     reg_wdata
);
    import exec_pkg::*;

    logic [apb_addr_width-1:0] offset;  // address relative to the register window.
    logic                      hit_reg;
    logic                      hit_ret;
    logic                      hit_ill;
    logic                      addr_err;

    // setup phase decode, held through the access phase.
    logic                      sel_reg_q;
    logic                      sel_ret_q;
    logic                      sel_ill_q;
    logic                      err_q;
    logic [reg_addr_width-1:0] idx_q;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    assign offset   = paddr - addr_reg_base;
    assign hit_reg  = (paddr >= addr_reg_base) && (offset < reg_count * 8);
    assign hit_ret  = (paddr == addr_retired);
    assign hit_ill  = (paddr == addr_illegal);
    assign addr_err = (paddr[2:0] != 3'b000)                 // misaligned.
                    || !(hit_reg || hit_ret || hit_ill)      // unmapped.
                    || (pwrite && (hit_ret || hit_ill));     // counters are read only.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_reg_q <= 1'b0;
            sel_ret_q <= 1'b0;
            sel_ill_q <= 1'b0;
            err_q     <= 1'b0;
        end else if (psel && !penable) begin
            sel_reg_q <= hit_reg && !addr_err;
            sel_ret_q <= hit_ret && !addr_err;
            sel_ill_q <= hit_ill && !addr_err;
            err_q     <= addr_err;
        end
    end

    always_ff @(posedge clk) begin
        if (psel && !penable) begin
            idx_q <= offset[reg_addr_width+2:3];  // eight bytes per register.
        end
    end

    // ------------------------------------------------------------------------
    // access phase, completes only with an empty pipeline
    // ------------------------------------------------------------------------
    assign pready  = psel && penable && !busy;
    assign pslverr = pready && err_q;

    assign reg_we    = pready && pwrite && sel_reg_q;  // x0 dropped in the file.
    assign reg_addr  = idx_q;
    assign reg_wdata = pwdata;

    always_comb begin
        if (sel_reg_q) begin
            prdata = reg_rdata;
        end else if (sel_ret_q) begin
            prdata = xlen'(retired_count);  // zero extended.
        end else if (sel_ill_q) begin
            prdata = xlen'(illegal_count);
        end else begin
            prdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
    parameter int xlen      = exec_pkg::xlen,
    parameter int reg_count = exec_pkg::reg_count
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [31:0]                         instr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [exec_pkg::apb_addr_width-1:0] paddr,
    input  logic [xlen-1:0]                     pwdata,
    output logic [xlen-1:0]                     prdata,
    output logic                                pready,
    output logic                                pslverr
);
    import exec_pkg::*;

    // read stage.
    logic                      rd_valid;
    alu_op_t                   rd_op;
    logic [reg_addr_width-1:0] rd_rs1;
    logic [reg_addr_width-1:0] rd_rs2;
    logic [reg_addr_width-1:0] rd_rd;
    logic [xlen-1:0]           rs1_file;
    logic [xlen-1:0]           rs2_file;
    logic [xlen-1:0]           op_a;
    logic [xlen-1:0]           op_b;

    // in-flight producers.
    logic                      ex_valid;
    logic [reg_addr_width-1:0] ex_rd;
    logic [xlen-1:0]           ex_result;
    logic                      mem_valid;
    logic [reg_addr_width-1:0] mem_rd;
    logic [xlen-1:0]           mem_result;
    logic                      wb_valid;
    logic [reg_addr_width-1:0] wb_rd;
    logic [xlen-1:0]           wb_result;

    // state port.
    logic [31:0]               retired_count;
    logic [31:0]               illegal_count;
    logic                      busy;
    logic                      reg_we;
    logic [reg_addr_width-1:0] reg_addr;
    logic [xlen-1:0]           reg_wdata;
    logic [xlen-1:0]           reg_rdata;

    // ------------------------------------------------------------------------
    // input side
    // ------------------------------------------------------------------------
    instr_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr),
        .rd_valid(rd_valid), .rd_op(rd_op),
        .rd_rs1(rd_rs1), .rd_rs2(rd_rs2), .rd_rd(rd_rd),
        .illegal_count(illegal_count)
    );

    // ------------------------------------------------------------------------
    // register file, bypass and execute
    // ------------------------------------------------------------------------
    reg_file #(.xlen(xlen), .reg_count(reg_count)) u_regs (
        .clk(clk), .rst_n(rst_n),
        .rs1(rd_rs1), .rs2(rd_rs2),
        .wb_en(wb_valid), .wb_addr(wb_rd), .wb_data(wb_result),
        .apb_we(reg_we), .apb_addr(reg_addr), .apb_wdata(reg_wdata),
        .rs1_data(rs1_file), .rs2_data(rs2_file), .apb_rdata(reg_rdata)
    );

    operand_bypass #(.xlen(xlen)) u_bypass (
        .rs1(rd_rs1), .rs2(rd_rs2),
        .rs1_file(rs1_file), .rs2_file(rs2_file),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
        .mem_valid(mem_valid), .mem_rd(mem_rd), .mem_result(mem_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_result(wb_result),
        .op_a(op_a), .op_b(op_b)
    );

    exec_pipe #(.xlen(xlen)) u_pipe (
        .clk(clk), .rst_n(rst_n),
        .rd_valid(rd_valid), .rd_op(rd_op), .rd_rd(rd_rd),
        .op_a(op_a), .op_b(op_b),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
        .mem_valid(mem_valid), .mem_rd(mem_rd), .mem_result(mem_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_result(wb_result),
        .retired_count(retired_count), .busy(busy)
    );

    // ------------------------------------------------------------------------
    // output side
    // ------------------------------------------------------------------------
    apb_state_port #(.xlen(xlen)) u_apb (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .busy(busy), .reg_rdata(reg_rdata),
        .retired_count(retired_count), .illegal_count(illegal_count),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata)
    );

endmodule

`default_nettype wire

// ==== verif/exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
    import exec_pkg::*;

    localparam int data_w    = 64;  // rv64 datapath.
    localparam int num_tests = 6;
    localparam int max_len   = 8;   // instructions per table entry.
    localparam int err_test  = 5;   // entry that also runs the apb error cases.

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    logic [31:0]       instr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [11:0]       paddr;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // ------------------------------------------------------------------------
    // test table and reference state
    // ------------------------------------------------------------------------
    string       test_name [num_tests];
    int          test_len  [num_tests];
    int          test_gap  [num_tests];  // cycles between issued words.
    logic [31:0] prog      [num_tests][max_len];

    logic [data_w-1:0] model_regs [32];  // architectural registers in program order.
    logic [31:0]       model_retired;
    logic [31:0]       model_illegal;
    logic [63:0]       rng_state;
    int                errors       = 0;
    int                checks       = 0;
    int                failed_tests = 0;
    int                cycles       = 0;
    int                cycle_limit  = 0;

    exec_top #(.xlen(data_w), .reg_count(32)) uut (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #10 clk = ~clk;  // 20 ns period.

    // run limit worked out from the table before reset.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("timeout after %0d cycles, a transfer or the pipeline never finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // r-type word from an operation and register numbers.
    function automatic logic [31:0] encode_r(input alu_op_t op, input int rd,
                                             input int rs1, input int rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'b0000000;
        f3 = 3'b000;  // add.
        case (op)
            alu_sub: f7 = 7'b0100000;
            alu_sll: f3 = 3'b001;
            alu_xor: f3 = 3'b100;
            alu_srl: f3 = 3'b101;
            alu_or:  f3 = 3'b110;
            alu_and: f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic int cycle_budget();
        int total;
        total = 10;  // reset.
        for (int t = 0; t < num_tests; t++) begin
            total += 3 * (32 + 1 + 34 + 5) + test_len[t] * test_gap[t] + 8;
        end
        return total * 2;
    endfunction

    // sequential reference applied one word at a time.
    task automatic model_step(input logic [31:0] w);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic        legal;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        r     = '0;
        legal = (w[6:0] == 7'b0110011);
        if (legal) begin
            case ({w[31:25], w[14:12]})
                {7'h00, 3'b000}: r = a + b;
                {7'h20, 3'b000}: r = a - b;
                {7'h00, 3'b001}: r = a << b[5:0];  // low six bits only.
                {7'h00, 3'b100}: r = a ^ b;
                {7'h00, 3'b101}: r = a >> b[5:0];
                {7'h00, 3'b110}: r = a | b;
                {7'h00, 3'b111}: r = a & b;
                default:         legal = 1'b0;
            endcase
        end
        if (legal) begin
            model_retired += 1;
            if (w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = r;  // x0 retires without effect.
            end
        end else begin
            model_illegal += 1;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks += 1;
        if (expected !== actual) begin
            errors += 1;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // apb master entered and left 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [63:0] wdata, output logic [63:0] rdata,
                                output logic err);
        psel    = 1'b1;  // setup phase.
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;  // access phase.
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);  // held off while the pipeline drains.
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [63:0] wdata,
                             output logic err);
        logic [63:0] unused;
        apb_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [63:0] rdata,
                            output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic load_table();
        test_name[0] = "apb_rw";
        test_len[0]  = 0;
        test_gap[0]  = 1;
        test_name[1] = "independent";
        test_len[1]  = 7;
        test_gap[1]  = 5;
        prog[1][0] = encode_r(alu_add, 1, 2, 3);
        prog[1][1] = encode_r(alu_sub, 4, 5, 6);
        prog[1][2] = encode_r(alu_and, 7, 8, 9);
        prog[1][3] = encode_r(alu_or, 10, 11, 12);
        prog[1][4] = encode_r(alu_xor, 13, 14, 15);
        prog[1][5] = encode_r(alu_sll, 16, 17, 18);
        prog[1][6] = encode_r(alu_srl, 19, 20, 21);
        test_name[2] = "chain";  // execute bypass.
        test_len[2]  = 6;
        test_gap[2]  = 1;
        prog[2][0] = encode_r(alu_add, 3, 1, 2);
        prog[2][1] = encode_r(alu_add, 4, 3, 3);
        prog[2][2] = encode_r(alu_sll, 5, 4, 4);
        prog[2][3] = encode_r(alu_or, 6, 5, 5);
        prog[2][4] = encode_r(alu_srl, 7, 6, 6);
        prog[2][5] = encode_r(alu_and, 8, 7, 7);
        test_name[3] = "distance";
        test_len[3]  = 8;
        test_gap[3]  = 1;
        prog[3][0] = encode_r(alu_add, 3, 1, 2);
        prog[3][1] = encode_r(alu_xor, 4, 5, 6);
        prog[3][2] = encode_r(alu_sub, 7, 3, 9);    // x3 from memory.
        prog[3][3] = encode_r(alu_or, 8, 3, 4);     // write-back and memory.
        prog[3][4] = encode_r(alu_add, 3, 10, 11);
        prog[3][5] = encode_r(alu_add, 3, 3, 12);   // newer x3 over older.
        prog[3][6] = encode_r(alu_sll, 9, 3, 7);    // youngest x3 with x7 from the file.
        prog[3][7] = encode_r(alu_xor, 10, 3, 9);   // memory x3 over write-back x3.
        test_name[4] = "illegal";
        test_len[4]  = 8;
        test_gap[4]  = 1;
        prog[4][0] = encode_r(alu_add, 1, 2, 3);
        prog[4][1] = 32'h0000_0013;                                  // addi opcode.
        prog[4][2] = encode_r(alu_add, 0, 1, 2);                     // write to x0.
        prog[4][3] = {7'h00, 5'd2, 5'd1, 3'b010, 5'd5, 7'b0110011};  // slt.
        prog[4][4] = encode_r(alu_sub, 6, 0, 1);
        prog[4][5] = {7'h01, 5'd3, 5'd2, 3'b000, 5'd7, 7'b0110011};  // mul.
        prog[4][6] = {7'h20, 5'd3, 5'd2, 3'b101, 5'd8, 7'b0110011};  // sra.
        prog[4][7] = encode_r(alu_or, 9, 6, 1);
        test_name[5] = "apb_errors";
        test_len[5]  = 3;
        test_gap[5]  = 1;
        prog[5][0] = encode_r(alu_add, 2, 1, 1);
        prog[5][1] = encode_r(alu_sll, 3, 2, 1);
        prog[5][2] = encode_r(alu_srl, 4, 3, 2);
    endtask

    task automatic run_test(input int t);
        int          err_before;
        logic [31:0] last_word;
        logic [63:0] val;
        logic [63:0] rdata;
        logic        err;
        err_before = errors;
        for (int n = 0; n < 32; n++) begin
            rng_state = xorshift(rng_state);
            val       = rng_state;
            apb_write(12'(n * 8), val, err);  // x0 write is ignored.
            check_value($sformatf("%s preload x%0d pslverr", test_name[t], n), '0, err);
            if (n != 0) begin
                model_regs[n] = val;
            end
        end
        for (int i = 0; i < test_len[t]; i++) begin
            instr_valid = 1'b1;
            instr       = prog[t][i];
            model_step(prog[t][i]);
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            repeat (test_gap[t] - 1) begin
                @(posedge clk);
                #1;
            end
        end
        if (test_len[t] > 0) begin
            last_word = prog[t][test_len[t] - 1];  // started with the pipe still busy.
            apb_read(12'(last_word[11:7] * 8), rdata, err);
            check_value($sformatf("%s in-flight x%0d", test_name[t], last_word[11:7]),
                        model_regs[last_word[11:7]], rdata);
        end
        for (int n = 0; n < 32; n++) begin
            apb_read(12'(n * 8), rdata, err);
            check_value($sformatf("%s x%0d", test_name[t], n), model_regs[n], rdata);
        end
        apb_read(addr_retired, rdata, err);
        check_value($sformatf("%s retired", test_name[t]), {32'd0, model_retired}, rdata);
        apb_read(addr_illegal, rdata, err);
        check_value($sformatf("%s illegal", test_name[t]), {32'd0, model_illegal}, rdata);
        if (t == err_test) begin
            apb_read(12'h200, rdata, err);
            check_value("apb unmapped pslverr", 64'd1, err);
            apb_read(12'h00c, rdata, err);
            check_value("apb misaligned pslverr", 64'd1, err);
            apb_write(addr_retired, 64'h55, err);
            check_value("apb counter write pslverr", 64'd1, err);
            apb_read(addr_retired, rdata, err);
            check_value("apb counter after write", {32'd0, model_retired}, rdata);
        end
        if (errors == err_before) begin
            $display("test %-12s ok", test_name[t]);
        end else begin
            failed_tests += 1;
            $display("test %-12s %0d mismatches", test_name[t], errors - err_before);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        rng_state     = 64'd4;  // seed.
        model_retired = '0;
        model_illegal = '0;
        for (int n = 0; n < 32; n++) begin
            model_regs[n] = '0;
        end
        load_table();
        cycle_limit = cycle_budget();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 num_tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rvseed_exec.f ====
design/exec_pkg.sv
design/instr_decode.sv
design/reg_file.sv
design/operand_bypass.sv
design/exec_pipe.sv
design/apb_state_port.sv
design/exec_top.sv
verif/exec_tb.sv
